/* bench/matchedFilterBench.sv */
`include "mf_consts.svh"

module matchedFilterBench;

	localparam int Period = 8;
	localparam int Taps = `MF_TAPS;
	localparam int Run1Samples = 200;
	localparam int IdleSamples = 16;
	localparam int Run2Samples = 60;
	localparam int SampleSlots = 2 * (Run1Samples + IdleSamples + Run2Samples); // A gap may follow each sample.
	localparam int BusTransfers = 3 * 19 + 23; // Three register scans plus all writes.
	localparam int Timeout = (SampleSlots + BusTransfers * 4 + 100) * Period;
	localparam logic [4:0] AddrRun = 5'(`MF_ADDR_RUN);

	logic clock = 1'b0;
	logic rstN;
	mfPkg::wbRequestT wbRequest;
	logic [31:0] wbDatOut;
	logic wbAck;
	logic sampleValid;
	logic signed [`MF_SAMPLE_WIDTH-1:0] sample;
	logic envelopeValid;
	logic [`MF_ENV_WIDTH-1:0] envelope;
	logic [`MF_ENV_WIDTH-1:0] peakMagnitude;
	logic [`MF_INDEX_WIDTH-1:0] peakIndex;
	logic running;

	logic [31:0] seed = 32'h5de1;
	int unsigned cycle = 0; // Rising edges seen so far.
	longint cRe [0:Taps-1];
	longint cIm [0:Taps-1];
	longint xHist [0:6];
	longint zRe [0:Taps-1];
	longint zIm [0:Taps-1];
	longint expEnvelope [$];
	int unsigned expCycle [$];
	longint peakModel;
	longint indexModel;
	longint envCount;

	matchedFilter i_matchedFilter (
		.clock         (clock),
		.rstN          (rstN),
		.wbRequest     (wbRequest),
		.wbDatOut      (wbDatOut),
		.wbAck         (wbAck),
		.sampleValid   (sampleValid),
		.sample        (sample),
		.envelopeValid (envelopeValid),
		.envelope      (envelope),
		.peakMagnitude (peakMagnitude),
		.peakIndex     (peakIndex),
		.running       (running)
	);

	initial begin
		forever #(Period / 2) clock = ~clock;
	end

	always @(posedge clock) cycle <= cycle + 1;

	initial begin
		#(Timeout);
		$display("Timeout: the run did not finish within %0d time units.", Timeout);
		$display("Simulation failed");
		$fatal(1, "Watchdog expired.");
	end

	//////////////////////////////////////////////////
	// Checking helpers
	//////////////////////////////////////////////////

	function automatic logic [31:0] nextRandom();
		seed = seed ^ (seed << 13); // Xorshift32.
		seed = seed ^ (seed >> 17);
		seed = seed ^ (seed << 5);
		return seed;
	endfunction

	function automatic longint magnitude(input longint v);
		return (v < 0) ? -v : v;
	endfunction

	task automatic reportFailure(input string what);
		$display("%s", what);
		$display("Simulation failed");
		$fatal(1, "Test stopped.");
	endtask

	task automatic check(input string name, input logic signed [63:0] expected,
		input logic signed [63:0] actual);
		if (expected !== actual) begin
			$display("MISMATCH %s: expected %0d, actual %0d", name, expected, actual);
			$display("Simulation failed");
			$fatal(1, "Check %s failed.", name);
		end
	endtask

	//////////////////////////////////////////////////
	// Wishbone master tasks called on a falling edge
	//////////////////////////////////////////////////

	task automatic busTransfer(input logic we, input logic [4:0] adr, input logic [31:0] dat,
		output logic [31:0] readData);
		int waited;
		waited = 0;
		wbRequest.cyc = 1'b1;
		wbRequest.stb = 1'b1;
		wbRequest.we = we;
		wbRequest.adr = adr;
		wbRequest.dat = dat;
		do begin
			@(negedge clock);
			waited++;
		end while (!wbAck && waited < 8);
		if (!wbAck) begin
			reportFailure("The register bank gave no acknowledge within 8 cycles.");
		end else begin
			readData = wbDatOut;
			wbRequest.cyc = 1'b0; // Drop the strobe in the acknowledged cycle.
			wbRequest.stb = 1'b0;
			wbRequest.we = 1'b0;
		end
	endtask

	task automatic wbWrite(input logic [4:0] adr, input logic [31:0] dat);
		logic [31:0] unused;
		busTransfer(1'b1, adr, dat, unused);
	endtask

	// Reads the whole map and compares it with the model's coefficients.
	task automatic checkRegisters(input string name, input logic expectRun);
		logic [31:0] rd;
		for (int a = 0; a < 2 * Taps; a++) begin
			busTransfer(1'b0, 5'(a), '0, rd);
			if (a < Taps) check(name, cRe[a], $signed(rd));
			else check(name, cIm[a - Taps], $signed(rd)); // Imaginary halves are sign-extended.
		end
		busTransfer(1'b0, AddrRun, '0, rd);
		check(name, expectRun, rd);
		busTransfer(1'b0, 5'd17, '0, rd);
		check(name, 0, rd);
		busTransfer(1'b0, 5'd31, '0, rd);
		check(name, 0, rd);
	endtask

	//////////////////////////////////////////////////
	// Reference model
	//////////////////////////////////////////////////

	task automatic modelClear();
		for (int k = 0; k < 7; k++)
			xHist[k] = 0;
		for (int k = 0; k < Taps; k++) begin
			zRe[k] = 0;
			zIm[k] = 0;
		end
		peakModel = 0;
		indexModel = 0;
		envCount = 0;
	endtask

	task automatic modelSample(input longint x);
		longint yRe;
		longint yIm;
		longint env;
		for (int k = 6; k > 0; k--)
			xHist[k] = xHist[k-1];
		xHist[0] = x;
		for (int k = Taps - 1; k > 0; k--) begin
			zRe[k] = zRe[k-1];
			zIm[k] = zIm[k-1];
		end
		zRe[0] = 4 * xHist[3];
		zIm[0] = -xHist[0] - 3 * xHist[2] + 3 * xHist[4] + xHist[6];
		yRe = 0;
		yIm = 0;
		for (int k = 0; k < Taps; k++) begin
			yRe += cRe[k] * zRe[k] - cIm[k] * zIm[k];
			yIm += cRe[k] * zIm[k] + cIm[k] * zRe[k];
		end
		env = magnitude(yRe) + magnitude(yIm);
		if (env > peakModel) begin // First of equal peaks stays.
			peakModel = env;
			indexModel = envCount;
		end
		envCount++;
		expEnvelope.push_back(env);
		expCycle.push_back(cycle);
	endtask

	// Drives count samples, each followed by a random gap of at most one cycle.
	task automatic streamSamples(input int count, input bit expectOutput);
		logic [31:0] r;
		for (int i = 0; i < count; i++) begin
			r = nextRandom();
			sampleValid = 1'b1;
			sample = r[11:0];
			if (expectOutput) modelSample($signed(r[11:0]));
			@(negedge clock);
			if (r[31]) begin
				sampleValid = 1'b0;
				@(negedge clock);
			end
		end
		sampleValid = 1'b0;
	endtask

	task automatic waitForDrain();
		int waited;
		waited = 0;
		while (expEnvelope.size() != 0 && waited < 10) begin
			@(negedge clock);
			waited++;
		end
		if (expEnvelope.size() != 0) reportFailure("Expected envelopes never arrived.");
	endtask

	// Every envelope must match the model and appear on the third rising edge after its sample.
	initial begin
		longint expected;
		int unsigned driven;
		forever begin
			@(negedge clock);
			if (rstN && envelopeValid) begin
				if (expEnvelope.size() == 0) begin
					reportFailure("envelopeValid was high with no sample pending.");
				end else begin
					expected = expEnvelope.pop_front();
					driven = expCycle.pop_front();
					check("envelope", expected, envelope);
					check("envelope latency", driven + 3, cycle);
				end
			end
		end
	end

	//////////////////////////////////////////////////
	// Test sequence
	//////////////////////////////////////////////////

	initial begin
		logic [31:0] r;
		wbRequest = '0;
		sampleValid = 1'b0;
		sample = '0;
		rstN = 1'b0;
		modelClear();
		for (int k = 0; k < Taps; k++) begin
			cRe[k] = 0;
			cIm[k] = 0;
		end
		repeat (2) @(negedge clock);
		rstN = 1'b1;

		check("reset running", 0, running);
		check("reset envelopeValid", 0, envelopeValid);
		check("reset wbAck", 0, wbAck);
		check("reset peakMagnitude", 0, peakMagnitude);
		check("reset peakIndex", 0, peakIndex);
		checkRegisters("reset readback", 1'b0);

		for (int k = 0; k < Taps; k++) begin
			r = nextRandom();
			wbWrite(5'(k), r);
			cRe[k] = $signed(r[11:0]);
			r = nextRandom();
			wbWrite(5'(k + Taps), r);
			cIm[k] = $signed(r[11:0]);
		end
		checkRegisters("coefficient readback", 1'b0);

		wbWrite(AddrRun, 32'd1);
		check("running after start", 1, running);
		streamSamples(Run1Samples / 2, 1'b1);
		for (int i = 0; i < 4; i++) begin
			r = nextRandom();
			wbWrite(5'(r[3:0]), nextRandom()); // Ignored while running.
		end
		streamSamples(Run1Samples - Run1Samples / 2, 1'b1);
		waitForDrain();
		check("run 1 peakMagnitude", peakModel, peakMagnitude);
		check("run 1 peakIndex", indexModel, peakIndex);
		checkRegisters("readback after writes in RUN", 1'b1);

		wbWrite(AddrRun, 32'd0);
		check("running after stop", 0, running);
		streamSamples(IdleSamples, 1'b0);
		repeat (4) @(negedge clock);
		check("envelopeValid in IDLE", 0, envelopeValid);

		modelClear();
		wbWrite(AddrRun, 32'd1);
		check("run 2 start peakMagnitude", 0, peakMagnitude);
		check("run 2 start peakIndex", 0, peakIndex);
		streamSamples(Run2Samples, 1'b1);
		waitForDrain();
		check("run 2 peakMagnitude", peakModel, peakMagnitude);
		check("run 2 peakIndex", indexModel, peakIndex);

		$display("Simulation completed successfully");
		$finish;
	end

endmodule

/* hdl/complexCorrelator.sv */
`include "mf_consts.svh"

module complexCorrelator (
	input  logic clock,
	input  logic rstN,
	input  logic running,
	input  logic analyticValid,
	input  mfPkg::analyticT analytic,
	input  mfPkg::coeffBankT coeffs,
	output logic correlationValid,
	output mfPkg::correlationT correlation
);

	localparam int Taps = `MF_TAPS;
	localparam int AccWidth = `MF_ACC_WIDTH;

	mfPkg::analyticT history [1:Taps-1]; // history[k] holds z[n-k].
	mfPkg::analyticT window [0:Taps-1];
	logic signed [AccWidth-1:0] sumRe;
	logic signed [AccWidth-1:0] sumIm;

	always_comb begin
		window[0] = analytic;
		for (int k = 1; k < Taps; k++) begin
			window[k] = history[k];
		end
	end

	//////////////////////////////////////////////////
	// Complex dot product
	//////////////////////////////////////////////////

	// (a + jb)(c + jd) = (ac - bd) + j(ad + bc), summed over all taps.
	// The accumulator width covers eight full-scale products, so nothing wraps.
	always_comb begin
		sumRe = '0;
		sumIm = '0;
		for (int k = 0; k < Taps; k++) begin
			sumRe = sumRe
				+ AccWidth'(window[k].re) * AccWidth'(coeffs[k].re)
				- AccWidth'(window[k].im) * AccWidth'(coeffs[k].im);
			sumIm = sumIm
				+ AccWidth'(window[k].re) * AccWidth'(coeffs[k].im)
				+ AccWidth'(window[k].im) * AccWidth'(coeffs[k].re);
		end
	end

	always_ff @(posedge clock) begin
		if (!rstN || !running) begin
			correlationValid <= 1'b0;
			correlation <= '0;
			for (int k = 1; k < Taps; k++) begin
				history[k] <= '0;
			end
		end else begin
			correlationValid <= analyticValid;
			if (analyticValid) begin
				correlation.re <= sumRe;
				correlation.im <= sumIm;
				history[1] <= analytic;
				for (int k = 2; k < Taps; k++) begin
					history[k] <= history[k-1];
				end
			end
		end
	end

endmodule

/* hdl/envelopeDetector.sv */
`include "mf_consts.svh"

module envelopeDetector (
	input  logic clock,
	input  logic rstN,
	input  logic running,
	input  logic correlationValid,
	input  mfPkg::correlationT correlation,
	output logic envelopeValid,
	output logic [`MF_ENV_WIDTH-1:0] envelope,
	output logic [`MF_ENV_WIDTH-1:0] peakMagnitude,
	output logic [`MF_INDEX_WIDTH-1:0] peakIndex
);

	localparam int EnvWidth = `MF_ENV_WIDTH;
	localparam int IndexWidth = `MF_INDEX_WIDTH;

	logic [EnvWidth-1:0] magRe;
	logic [EnvWidth-1:0] magIm;
	logic [EnvWidth-1:0] envNext;
	logic [IndexWidth-1:0] count; // Index n of the next envelope in this run.

	// Widen before negating so that the most negative input has a valid magnitude.
	always_comb begin
		magRe = EnvWidth'(correlation.re);
		magIm = EnvWidth'(correlation.im);
		if (correlation.re < 0) magRe = -magRe;
		if (correlation.im < 0) magIm = -magIm;
		envNext = magRe + magIm;
	end

	always_ff @(posedge clock) begin
		if (!rstN || !running) begin
			envelopeValid <= 1'b0;
			envelope <= '0;
			peakMagnitude <= '0;
			peakIndex <= '0;
			count <= '0;
		end else begin
			envelopeValid <= correlationValid;
			if (correlationValid) begin
				envelope <= envNext;
				count <= count + 1'b1;
				if (envNext > peakMagnitude) begin // Strict compare keeps the first of equal peaks.
					peakMagnitude <= envNext;
					peakIndex <= count;
				end
			end
		end
	end

endmodule

/* hdl/hilbertTransform.sv */
`include "mf_consts.svh"

module hilbertTransform (
	input  logic clock,
	input  logic rstN,
	input  logic running,
	input  logic sampleValid,
	input  logic signed [`MF_SAMPLE_WIDTH-1:0] sample,
	output logic analyticValid,
	output mfPkg::analyticT analytic
);

	localparam int SampleWidth = `MF_SAMPLE_WIDTH;
	localparam int AnalyticWidth = `MF_ANALYTIC_WIDTH;
	localparam int Length = `MF_HT_LENGTH;

	logic accept;
	logic signed [SampleWidth-1:0] delayLine [1:Length-1]; // delayLine[k] holds x[n-k].
	logic signed [AnalyticWidth-1:0] window [0:Length-1];
	logic signed [AnalyticWidth-1:0] realNext;
	logic signed [AnalyticWidth-1:0] imagNext;

	assign accept = sampleValid && running;

	// Seven-sample window, the live input plus the stored history.
	always_comb begin
		window[0] = AnalyticWidth'(sample);
		for (int k = 1; k < Length; k++) begin
			window[k] = AnalyticWidth'(delayLine[k]);
		end
	end

	assign realNext = AnalyticWidth'(`MF_HT_GAIN * window[`MF_HT_DELAY]);

	// Odd taps are zero. The even taps pair up around the centre with opposite signs.
	assign imagNext = AnalyticWidth'(`MF_HT_TAP_OUTER * (window[Length-1] - window[0])
		+ `MF_HT_TAP_INNER * (window[Length-3] - window[2]));

	always_ff @(posedge clock) begin
		if (!rstN || !running) begin
			analyticValid <= 1'b0;
			analytic <= '0;
			for (int k = 1; k < Length; k++) begin
				delayLine[k] <= '0; // A new run starts from zero history.
			end
		end else begin
			analyticValid <= accept;
			if (accept) begin
				analytic.re <= realNext;
				analytic.im <= imagNext;
				delayLine[1] <= sample;
				for (int k = 2; k < Length; k++) begin
					delayLine[k] <= delayLine[k-1];
				end
			end
		end
	end

endmodule

/* hdl/matchedFilter.sv */
`include "mf_consts.svh"

module matchedFilter (
	input  logic clock,
	input  logic rstN,
	input  mfPkg::wbRequestT wbRequest,
	output logic [31:0] wbDatOut,
	output logic wbAck,
	input  logic sampleValid,
	input  logic signed [`MF_SAMPLE_WIDTH-1:0] sample,
	output logic envelopeValid,
	output logic [`MF_ENV_WIDTH-1:0] envelope,
	output logic [`MF_ENV_WIDTH-1:0] peakMagnitude,
	output logic [`MF_INDEX_WIDTH-1:0] peakIndex,
	output logic running
);

	mfPkg::coeffBankT coeffs;
	logic analyticValid;
	mfPkg::analyticT analytic;
	logic correlationValid;
	mfPkg::correlationT correlation;

	//////////////////////////////////////////////////
	// Host registers
	//////////////////////////////////////////////////

	mfRegisterBank i_mfRegisterBank (
		.clock     (clock),
		.rstN      (rstN),
		.wbRequest (wbRequest),
		.wbDatOut  (wbDatOut),
		.wbAck     (wbAck),
		.coeffs    (coeffs),
		.running   (running)
	);

	//////////////////////////////////////////////////
	// Sample pipeline, one cycle per stage
	//////////////////////////////////////////////////

	hilbertTransform i_hilbertTransform (
		.clock         (clock),
		.rstN          (rstN),
		.running       (running),
		.sampleValid   (sampleValid),
		.sample        (sample),
		.analyticValid (analyticValid),
		.analytic      (analytic)
	);

	complexCorrelator i_complexCorrelator (
		.clock            (clock),
		.rstN             (rstN),
		.running          (running),
		.analyticValid    (analyticValid),
		.analytic         (analytic),
		.coeffs           (coeffs),
		.correlationValid (correlationValid),
		.correlation      (correlation)
	);

	envelopeDetector i_envelopeDetector (
		.clock            (clock),
		.rstN             (rstN),
		.running          (running),
		.correlationValid (correlationValid),
		.correlation      (correlation),
		.envelopeValid    (envelopeValid),
		.envelope         (envelope),
		.peakMagnitude    (peakMagnitude),
		.peakIndex        (peakIndex)
	);

endmodule

/* hdl/mfPkg.sv */
`include "mf_consts.svh"

package mfPkg;

	//////////////////////////////////////////////////
	// Control types
	//////////////////////////////////////////////////

	typedef enum logic {
		IDLE,
		RUN
	} mfStateT;

	// One classic Wishbone request as seen by the slave.
	typedef struct packed {
		logic cyc;
		logic stb;
		logic we;
		logic [`MF_ADR_WIDTH-1:0] adr;
		logic [`MF_DATA_WIDTH-1:0] dat;
	} wbRequestT;

	//////////////////////////////////////////////////
	// Sample types
	//////////////////////////////////////////////////

	typedef struct packed {
		logic signed [`MF_ANALYTIC_WIDTH-1:0] re;
		logic signed [`MF_ANALYTIC_WIDTH-1:0] im;
	} analyticT;

	typedef struct packed {
		logic signed [`MF_ACC_WIDTH-1:0] re;
		logic signed [`MF_ACC_WIDTH-1:0] im;
	} correlationT;

	typedef struct packed {
		logic signed [`MF_COEFF_WIDTH-1:0] re;
		logic signed [`MF_COEFF_WIDTH-1:0] im;
	} coeffT;

	typedef coeffT [`MF_TAPS-1:0] coeffBankT; // Element k multiplies z[n-k].

endpackage

/* hdl/mfRegisterBank.sv */
`include "mf_consts.svh"

module mfRegisterBank (
	input  logic clock,
	input  logic rstN,
	input  mfPkg::wbRequestT wbRequest,
	output logic [31:0] wbDatOut,
	output logic wbAck,
	output mfPkg::coeffBankT coeffs,
	output logic running
);

	localparam int AdrWidth = `MF_ADR_WIDTH;
	localparam int DataWidth = `MF_DATA_WIDTH;
	localparam int CoeffWidth = `MF_COEFF_WIDTH;
	localparam int TapBits = $clog2(`MF_TAPS);
	localparam logic [AdrWidth-1:0] AddrImag = AdrWidth'(`MF_ADDR_IMAG);
	localparam logic [AdrWidth-1:0] AddrRun = AdrWidth'(`MF_ADDR_RUN);

	mfPkg::mfStateT state;
	mfPkg::mfStateT nextState;
	logic request;
	logic writeRun;
	logic writeCoeff;
	logic [TapBits-1:0] tap;
	logic [DataWidth-1:0] readValue;

	// A transfer is taken once, in the cycle before its acknowledge.
	assign request = wbRequest.cyc && wbRequest.stb && !wbAck;
	assign writeRun = request && wbRequest.we && (wbRequest.adr == AddrRun);
	assign writeCoeff = request && wbRequest.we && (wbRequest.adr < AddrRun)
		&& (state == mfPkg::IDLE); // Coefficients are frozen during a run.
	assign tap = wbRequest.adr[TapBits-1:0];
	assign running = (state == mfPkg::RUN);

	//////////////////////////////////////////////////
	// Run control FSM
	//////////////////////////////////////////////////

	always_comb begin
		nextState = state;
		case (state)
			mfPkg::IDLE: begin
				if (writeRun && wbRequest.dat[0]) nextState = mfPkg::RUN;
			end
			mfPkg::RUN: begin
				if (writeRun && !wbRequest.dat[0]) nextState = mfPkg::IDLE;
			end
			default: nextState = mfPkg::IDLE;
		endcase
	end

	// Coefficient halves come back sign-extended to the bus width.
	always_comb begin
		readValue = '0;
		if (wbRequest.adr == AddrRun) begin
			readValue = DataWidth'(running);
		end else if (wbRequest.adr < AddrImag) begin
			readValue = DataWidth'($signed(coeffs[tap].re));
		end else if (wbRequest.adr < AddrRun) begin
			readValue = DataWidth'($signed(coeffs[tap].im));
		end
	end

	always_ff @(posedge clock) begin
		if (!rstN) begin
			wbAck <= 1'b0;
			state <= mfPkg::IDLE;
			coeffs <= '0;
		end else begin
			wbAck <= request; // Single-cycle acknowledge.
			state <= nextState;
			if (writeCoeff) begin
				if (wbRequest.adr < AddrImag) begin
					coeffs[tap].re <= wbRequest.dat[CoeffWidth-1:0];
				end else begin
					coeffs[tap].im <= wbRequest.dat[CoeffWidth-1:0];
				end
			end
		end
	end

	always_ff @(posedge clock) begin
		if (request) wbDatOut <= readValue; // Valid together with wbAck.
	end

endmodule

/* hdl/mf_consts.svh */
`ifndef MF_CONSTS_SVH
`define MF_CONSTS_SVH

// Data path widths in bits.
`define MF_SAMPLE_WIDTH   12
`define MF_ANALYTIC_WIDTH 16
`define MF_COEFF_WIDTH    12
`define MF_ACC_WIDTH      32
`define MF_ENV_WIDTH      33
`define MF_INDEX_WIDTH    16

`define MF_TAPS 8 // Correlator length.

// Wishbone register map, word addresses.
`define MF_ADR_WIDTH  5
`define MF_DATA_WIDTH 32
`define MF_ADDR_IMAG  8  // First imaginary coefficient.
`define MF_ADDR_RUN   16 // Control register, bit 0 is the run bit.

// Hilbert taps are -1, 0, -3, 0, 3, 0, 1, an antisymmetric set with two magnitudes.
`define MF_HT_LENGTH    7
`define MF_HT_DELAY     3 // Centre tap of the real path.
`define MF_HT_GAIN      4 // Real path gain, matches the imaginary DC-free gain.
`define MF_HT_TAP_INNER 3
`define MF_HT_TAP_OUTER 1

`endif

/* list.f */
+incdir+hdl
hdl/mfPkg.sv
hdl/mfRegisterBank.sv
hdl/hilbertTransform.sv
hdl/complexCorrelator.sv
hdl/envelopeDetector.sv
hdl/matchedFilter.sv
bench/matchedFilterBench.sv

/* run.sh */
#!/bin/sh
# Builds the matched filter testbench with Verilator and runs it.

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing -Wno-fatal --top-module matchedFilterBench -f list.f -o simv
status=$?
if [ $status -ne 0 ]; then
	echo "Verilator build failed with status $status"
	exit 1
fi

./obj_dir/simv > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -qx "Simulation completed successfully" sim.log; then
	exit 0
fi
echo "Pass message not found in sim.log"
exit 1
